// File: flist.f
+incdir+hdl
hdl/tdg_pkg.sv
hdl/game_sequencer.sv
hdl/unit_stats_rom.sv
hdl/unit_behavior.sv
hdl/unit_table.sv
hdl/purse_bank.sv
hdl/game_engine_top.sv
tb/game_engine_props.sv
tb/game_engine_tb.sv

// File: tb/game_engine_tb.sv
`timescale 1ns/100ps
`include "tdg_consts.svh"

module game_engine_tb;

    localparam int pass_limit  = 400;                           // Cycles from frame_tick to pass_done
    localparam int spawn_limit = 20;                            // Passes a spawn request may wait

    logic                 clk_25MHz;
    logic                 arst_n;
    logic                 frame_tick;
    tdg_pkg::spawn_req_t  enemy_spawn;
    tdg_pkg::spawn_req_t  army_spawn;
    logic                 upgrade_valid;
    logic                 enemy_spawn_ready;
    logic                 army_spawn_ready;
    logic                 upgrade_ready;
    logic                 pass_done;
    logic                 game_win;
    logic                 game_lose;
    logic [`MONEY_W-1:0]  money;
    logic [`LEVEL_W-1:0]  purse_level;
    tdg_pkg::unit_bank_t  enemy_units;
    tdg_pkg::unit_bank_t  army_units;
    logic [`HP_W-1:0]     enemy_tower_hp;
    logic [`HP_W-1:0]     army_tower_hp;

    int value_errors;
    int timeouts;
    bit took_e, took_a, took_u;                                 // Handshakes of the last pass
    int income_per_level [8] = '{1, 2, 2, 3, 4, 5, 5, 5};

    game_engine_top uut (.*);

    initial clk_25MHz = 1'b0;
    always #20 clk_25MHz = ~clk_25MHz;

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            value_errors++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic bit strike_due(input int p, input int p0, input int cd);
        return (p >= p0 + cd + 2) && ((p - p0 - cd - 2) % (2 * cd + 3) == 0);
    endfunction

    task automatic apply_reset();
        @(negedge clk_25MHz);
        arst_n        = 1'b0;
        frame_tick    = 1'b0;
        enemy_spawn   = '0;
        army_spawn    = '0;
        upgrade_valid = 1'b0;
        repeat (3) @(negedge clk_25MHz);
        arst_n = 1'b1;
    endtask

    task automatic run_pass(input bit quiet, output bit done);
        int         cycles;
        logic [2:0] ready_now;
        took_e = 1'b0;
        took_a = 1'b0;
        took_u = 1'b0;
        done   = 1'b0;
        cycles = 0;
        @(negedge clk_25MHz);
        frame_tick = 1'b1;
        @(negedge clk_25MHz);
        frame_tick = 1'b0;
        while (!done && cycles < pass_limit) begin
            ready_now = {enemy_spawn_ready, army_spawn_ready, upgrade_ready};
            if (took_e) enemy_spawn.valid = 1'b0;               // Withdrawn after acceptance
            if (took_a) army_spawn.valid = 1'b0;
            if (took_u) upgrade_valid = 1'b0;
            took_e |= ready_now[2];
            took_a |= ready_now[1];
            took_u |= ready_now[0];
            done = pass_done;
            if (!done) begin
                @(negedge clk_25MHz);
                cycles++;
            end
        end
        assert (done || quiet) else begin
            timeouts++;
            $display("Timeout: pass_done did not arrive within %0d cycles", pass_limit);
        end
    endtask

    task automatic spawn(input bit enemy, input tdg_pkg::unit_kind_e kind);
        int passes;
        bit done;
        bit taken;
        passes = 0;
        taken  = 1'b0;
        if (enemy) enemy_spawn = '{valid: 1'b1, kind: kind};
        else army_spawn = '{valid: 1'b1, kind: kind};
        while (!taken && passes < spawn_limit) begin
            run_pass(1'b0, done);
            taken = enemy ? took_e : took_a;
            passes++;
        end
        assert (taken) else begin
            timeouts++;
            $display("Timeout: spawn request not accepted within %0d passes", spawn_limit);
        end
    endtask

    task automatic econ_pass(inout int m, inout int lvl);
        bit want;
        bit done;
        want = upgrade_valid && (lvl < 7) && (m >= 50 * (lvl + 1));
        if (want) begin
            m = m - 50 * (lvl + 1);
            lvl++;
        end
        m = m + income_per_level[lvl];
        if (m > 200 + 100 * lvl) m = 200 + 100 * lvl;
        run_pass(1'b0, done);
        check_value("upgrade handshake", took_u, want);
        check_value("money", money, m);
        check_value("purse_level", purse_level, lvl);
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------
    task automatic test_reset();
        apply_reset();
        check_value("money", money, 0);
        check_value("purse_level", purse_level, 0);
        check_value("enemy_tower_hp", enemy_tower_hp, `TOWER_HP_INIT);
        check_value("army_tower_hp", army_tower_hp, `TOWER_HP_INIT);
        check_value("pass_done", pass_done, 0);
        check_value("readies", {enemy_spawn_ready, army_spawn_ready, upgrade_ready}, 0);
        for (int i = 0; i < `UNIT_SLOTS; i++) begin
            check_value($sformatf("enemy slot %0d exist", i), enemy_units[i].exist, 0);
            check_value($sformatf("army slot %0d exist", i), army_units[i].exist, 0);
        end
    endtask

    task automatic test_economy();
        int m;
        int lvl;
        apply_reset();
        m   = 0;
        lvl = 0;
        repeat (210) econ_pass(m, lvl);                         // Runs into the level 0 cap
        while (lvl < 7) begin
            upgrade_valid = 1'b1;
            econ_pass(m, lvl);
        end
        upgrade_valid = 1'b1;
        repeat (20) econ_pass(m, lvl);                          // Top level, stays unaccepted
        upgrade_valid = 1'b0;
    endtask

    // One lone unit walks to the opposing tower and then strikes it
    task automatic test_siege(input bit enemy, input tdg_pkg::unit_kind_e kind, input int speed,
                              input int range, input int cd, input int atk, input int passes);
        int x;
        int hp;
        int p0;
        bit done;
        apply_reset();
        x  = enemy ? `ENEMY_SPAWN_X : `ARMY_SPAWN_X;
        hp = `TOWER_HP_INIT;
        p0 = 0;
        for (int p = 1; p <= passes; p++) begin
            if (p == 1) spawn(enemy, kind);
            else run_pass(1'b0, done);
            if (p0 == 0) begin
                if (enemy ? (x + range >= `TOWER_A_X) : (`TOWER_E_X + range >= x)) p0 = p;
                else x = enemy ? x + speed : x - speed;
            end else if (strike_due(p, p0, cd)) begin
                hp = (hp > atk) ? hp - atk : 0;
            end
            check_value("unit x", enemy ? enemy_units[0].x : army_units[0].x, x);
            check_value("tower hp", enemy ? army_tower_hp : enemy_tower_hp, hp);
        end
    endtask

    task automatic test_combat();
        int p;
        int ex, ax;
        int e_dmg, a_dmg;
        int e_p0, a_p0;
        bit done;
        apply_reset();
        enemy_spawn = '{valid: 1'b1, kind: tdg_pkg::SCOUT};
        army_spawn  = '{valid: 1'b1, kind: tdg_pkg::TANK};
        ex    = `ENEMY_SPAWN_X;
        ax    = `ARMY_SPAWN_X;
        e_dmg = 0;
        a_dmg = 0;
        e_p0  = 0;
        a_p0  = 0;
        p     = 0;
        while (e_dmg < 100 && p < 400) begin
            p++;
            run_pass(1'b0, done);
            if (e_p0 == 0) begin                                // Enemies act first
                if (ex + 20 >= ax) e_p0 = p;
                else ex = ex + 8;
            end else if (strike_due(p, e_p0, 2)) begin
                a_dmg += 20;
            end
            if (a_p0 == 0) begin
                if (ax <= ex + 10) a_p0 = p;
                else ax = ax - 2;
            end else if (strike_due(p, a_p0, 6)) begin
                e_dmg += 10;
            end
            check_value("tank hp", army_units[0].hp, 800 - a_dmg);
            check_value("tank x", army_units[0].x, ax);
            check_value("scout present", enemy_units[0].exist, e_dmg < 100);
            if (e_dmg < 100) begin
                check_value("scout hp", enemy_units[0].hp, 100 - e_dmg);
                check_value("scout x", enemy_units[0].x, ex);
            end
        end
        spawn(1'b1, tdg_pkg::BRUTE);
        check_value("slot 0 reused", enemy_units[0].exist, 1);
        check_value("slot 0 kind", enemy_units[0].kind, tdg_pkg::BRUTE);
        check_value("slot 0 hp", enemy_units[0].hp, 400);
    endtask

    task automatic test_backpressure();
        bit done;
        apply_reset();
        for (int i = 0; i < `UNIT_SLOTS; i++) begin
            spawn(1'b1, tdg_pkg::TANK);
            check_value($sformatf("enemy slot %0d exist", i), enemy_units[i].exist, 1);
        end
        enemy_spawn = '{valid: 1'b1, kind: tdg_pkg::SCOUT};
        repeat (5) begin
            run_pass(1'b0, done);
            check_value("enemy_spawn_ready with full bank", took_e, 0);
            check_value("last enemy slot exist", enemy_units[`UNIT_SLOTS-1].exist, 1);
        end
        enemy_spawn = '0;
    endtask

    task automatic test_win();
        int spawned;
        int guard;
        bit done;
        apply_reset();
        spawned = 0;
        guard   = 0;
        while (!game_win && guard < 800) begin
            if (spawned < `UNIT_SLOTS) army_spawn = '{valid: 1'b1, kind: tdg_pkg::BRUTE};
            run_pass(1'b0, done);
            if (took_a) spawned++;
            guard++;
        end
        check_value("game_win", game_win, 1);
        check_value("game_lose", game_lose, 0);
        check_value("enemy_tower_hp", enemy_tower_hp, 0);
        run_pass(1'b1, done);                                   // No pass once the game is over
        assert (!done) else begin
            value_errors++;
            $display("Fail at %0t ns: a pass ran after the game was won", $time);
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        arst_n        = 1'b0;
        frame_tick    = 1'b0;
        enemy_spawn   = '0;
        army_spawn    = '0;
        upgrade_valid = 1'b0;
        value_errors  = 0;
        timeouts      = 0;
        test_reset();
        test_economy();
        test_siege(1'b0, tdg_pkg::SCOUT, 8, 20, 2, 20, 75);
        test_siege(1'b1, tdg_pkg::BRUTE, 4, 10, 4, 40, 160);
        test_siege(1'b0, tdg_pkg::BRUTE, 4, 10, 4, 40, 155);
        test_siege(1'b0, tdg_pkg::TANK, 2, 10, 6, 10, 272);
        test_combat();
        test_backpressure();
        test_win();
        $display("Errors: %0d value, %0d timeout, %0d property",
                 value_errors, timeouts, uut.props.fail_count);
        if (value_errors == 0 && timeouts == 0 && uut.props.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tb/game_engine_props.sv
`timescale 1ns/100ps
`include "tdg_consts.svh"

module game_engine_props (
    input logic                 clk_25MHz,
    input logic                 arst_n,
    input logic                 pass_done,
    input logic                 enemy_spawn_ready,
    input logic                 army_spawn_ready,
    input tdg_pkg::unit_bank_t  enemy_units,
    input tdg_pkg::unit_bank_t  army_units,
    input logic [`MONEY_W-1:0]  money,
    input logic [`LEVEL_W-1:0]  purse_level,
    input logic [`HP_W-1:0]     enemy_tower_hp,
    input logic [`HP_W-1:0]     army_tower_hp
);

    int   fail_count = 0;                                       // Read by the testbench
    logic enemy_full;
    logic army_full;

    always_comb begin
        enemy_full = 1'b1;
        army_full  = 1'b1;
        for (int i = 0; i < `UNIT_SLOTS; i++) begin
            enemy_full &= enemy_units[i].exist;
            army_full  &= army_units[i].exist;
        end
    end

    // ----------------------------------------------------------
    // Handshake and game-state properties
    // ----------------------------------------------------------
    pass_done_pulse: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        pass_done |=> !pass_done)
    else begin
        $error("pass_done held for more than one cycle");
        fail_count++;
    end

    no_spawn_when_full: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        (enemy_full |-> !enemy_spawn_ready) and (army_full |-> !army_spawn_ready))
    else begin
        $error("spawn ready given to a full bank");
        fail_count++;
    end

    money_under_cap: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        money <= 200 + 100 * purse_level)
    else begin
        $error("money above the cap of its level");
        fail_count++;
    end

    towers_never_heal: assert property (@(posedge clk_25MHz) disable iff (!arst_n)
        (enemy_tower_hp <= $past(enemy_tower_hp)) && (army_tower_hp <= $past(army_tower_hp)))
    else begin
        $error("tower hit points rose");
        fail_count++;
    end

endmodule

bind game_engine_top game_engine_props props (.*);

// File: hdl/game_engine_top.sv
`timescale 1ns/100ps
`include "tdg_consts.svh"

module game_engine_top (
    input  logic                  clk_25MHz,
    input  logic                  arst_n,
    input  logic                  frame_tick,
    input  tdg_pkg::spawn_req_t   enemy_spawn,
    input  tdg_pkg::spawn_req_t   army_spawn,
    input  logic                  upgrade_valid,
    output logic                  enemy_spawn_ready,
    output logic                  army_spawn_ready,
    output logic                  upgrade_ready,
    output logic                  pass_done,
    output logic                  game_win,
    output logic                  game_lose,
    output logic [`MONEY_W-1:0]   money,
    output logic [`LEVEL_W-1:0]   purse_level,
    output tdg_pkg::unit_bank_t   enemy_units,
    output tdg_pkg::unit_bank_t   army_units,
    output logic [`HP_W-1:0]      enemy_tower_hp,
    output logic [`HP_W-1:0]      army_tower_hp
);

    tdg_pkg::game_phase_e phase;
    logic [`SLOT_W-1:0]   slot, target;
    logic                 target_end, enemy_slot_done, army_slot_done;
    tdg_pkg::hit_t        hit_on_army, hit_on_enemy;

    game_sequencer sequencer (
        .clk_25MHz(clk_25MHz), .arst_n(arst_n), .frame_tick(frame_tick),
        .slot_done(enemy_slot_done | army_slot_done),           // Only the acting side drives it
        .game_win(game_win), .game_lose(game_lose), .phase(phase), .slot(slot),
        .target(target), .target_end(target_end), .pass_done(pass_done)
    );

    unit_table #(.side_enemy(1'b1)) enemy_table (
        .clk_25MHz(clk_25MHz), .arst_n(arst_n), .phase(phase), .slot(slot), .target(target),
        .target_end(target_end), .spawn(enemy_spawn), .spawn_ready(enemy_spawn_ready),
        .foe_bank(army_units), .hit_in(hit_on_enemy), .hit_out(hit_on_army),
        .bank(enemy_units), .slot_done(enemy_slot_done), .foe_tower_hp(army_tower_hp),
        .foe_tower_down(game_lose)
    );

    unit_table #(.side_enemy(1'b0)) army_table (
        .clk_25MHz(clk_25MHz), .arst_n(arst_n), .phase(phase), .slot(slot), .target(target),
        .target_end(target_end), .spawn(army_spawn), .spawn_ready(army_spawn_ready),
        .foe_bank(enemy_units), .hit_in(hit_on_army), .hit_out(hit_on_enemy),
        .bank(army_units), .slot_done(army_slot_done), .foe_tower_hp(enemy_tower_hp),
        .foe_tower_down(game_win)
    );

    purse_bank purse (
        .clk_25MHz(clk_25MHz), .arst_n(arst_n), .phase(phase), .upgrade_valid(upgrade_valid),
        .upgrade_ready(upgrade_ready), .money(money), .purse_level(purse_level)
    );

endmodule

// File: hdl/purse_bank.sv
`timescale 1ns/100ps
`include "tdg_consts.svh"

module purse_bank (
    input  logic                  clk_25MHz,
    input  logic                  arst_n,
    input  tdg_pkg::game_phase_e  phase,
    input  logic                  upgrade_valid,
    output logic                  upgrade_ready,
    output logic [`MONEY_W-1:0]   money,
    output logic [`LEVEL_W-1:0]   purse_level
);

    localparam logic [`MONEY_W-1:0] cost_step = 50;
    localparam logic [`MONEY_W-1:0] cap_base  = 200;
    localparam logic [`MONEY_W-1:0] cap_step  = 100;

    logic [`MONEY_W-1:0] cost, cap, income, money_up, money_sum;
    logic [`LEVEL_W-1:0] level_up;

    assign cost = ({{(`MONEY_W - `LEVEL_W){1'b0}}, purse_level} + 1'b1) * cost_step;

    assign upgrade_ready = (phase == tdg_pkg::ECONOMY) && upgrade_valid &&
                           (purse_level < `PURSE_MAX_LEVEL) && (money >= cost);

    always_comb begin
        money_up = upgrade_ready ? money - cost : money;        // Upgrade before income
        level_up = upgrade_ready ? purse_level + 1'b1 : purse_level;
        case (level_up)
            3'd0:       income = 1;
            3'd1, 3'd2: income = 2;
            3'd3:       income = 3;
            3'd4:       income = 4;
            default:    income = 5;
        endcase
        cap       = cap_base + cap_step * {{(`MONEY_W - `LEVEL_W){1'b0}}, level_up};
        money_sum = money_up + income;
    end

    always_ff @(posedge clk_25MHz or negedge arst_n) begin
        if (!arst_n) begin
            money       <= '0;
            purse_level <= '0;
        end else if (phase == tdg_pkg::ECONOMY) begin
            money       <= (money_sum > cap) ? cap : money_sum;
            purse_level <= level_up;
        end
    end

endmodule

// File: hdl/unit_table.sv
`timescale 1ns/100ps
`include "tdg_consts.svh"

module unit_table #(
    parameter bit side_enemy = 1'b1
) (
    input  logic                 clk_25MHz,
    input  logic                 arst_n,
    input  tdg_pkg::game_phase_e phase,
    input  logic [`SLOT_W-1:0]   slot,
    input  logic [`SLOT_W-1:0]   target,
    input  logic                 target_end,
    input  tdg_pkg::spawn_req_t  spawn,
    output logic                 spawn_ready,
    input  tdg_pkg::unit_bank_t  foe_bank,
    input  tdg_pkg::hit_t        hit_in,
    output tdg_pkg::hit_t        hit_out,
    output tdg_pkg::unit_bank_t  bank,
    output logic                 slot_done,
    output logic [`HP_W-1:0]     foe_tower_hp,
    output logic                 foe_tower_down
);

    localparam int idx_w = $clog2(`UNIT_SLOTS);
    localparam tdg_pkg::game_phase_e spawn_ph = side_enemy ? tdg_pkg::SPAWN_E : tdg_pkg::SPAWN_A;
    localparam tdg_pkg::game_phase_e act_ph   = side_enemy ? tdg_pkg::ACT_E : tdg_pkg::ACT_A;
    localparam tdg_pkg::game_phase_e hurt_ph  = side_enemy ? tdg_pkg::HURT_E : tdg_pkg::HURT_A;
    localparam logic [`X_W-1:0] spawn_x = side_enemy ? `ENEMY_SPAWN_X : `ARMY_SPAWN_X;

    tdg_pkg::unit_t       own, foe, own_next, new_unit;
    tdg_pkg::unit_stats_t act_stats, spawn_stats;
    logic [idx_w-1:0]     free_idx;
    logic                 free_found, act_apply, hit_foe, tower_hit, beh_done;
    logic [`HP_W-1:0]     atk_ext;

    // ----------------------------------------------------------
    // Acting unit and its current target
    // ----------------------------------------------------------
    assign own     = (slot < `UNIT_SLOTS) ? bank[slot[idx_w-1:0]] : '0;
    assign foe     = (target < `UNIT_SLOTS) ? foe_bank[target[idx_w-1:0]] : '0;
    assign atk_ext = {{(`HP_W - `ATK_W){1'b0}}, act_stats.atk};

    unit_stats_rom act_rom (.kind(own.kind), .stats(act_stats));
    unit_stats_rom spawn_rom (.kind(spawn.kind), .stats(spawn_stats));

    unit_behavior #(.side_enemy(side_enemy)) behavior (
        .own(own), .foe(foe), .stats(act_stats), .target_end(target_end),
        .own_next(own_next), .hit_foe(hit_foe), .tower_hit(tower_hit), .slot_done(beh_done)
    );

    assign act_apply      = (phase == act_ph) && (slot < `UNIT_SLOTS);
    assign slot_done      = (phase == act_ph) && beh_done;
    assign hit_out        = '{valid: act_apply && hit_foe, slot: target, amount: atk_ext};
    assign foe_tower_down = (foe_tower_hp == '0);

    // ----------------------------------------------------------
    // Spawn into the lowest free slot
    // ----------------------------------------------------------
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = `UNIT_SLOTS - 1; i >= 0; i--) begin
            if (!bank[i].exist) begin
                free_found = 1'b1;
                free_idx   = i[idx_w-1:0];
            end
        end
        new_unit       = '0;
        new_unit.exist = 1'b1;
        new_unit.kind  = spawn.kind;
        new_unit.x     = spawn_x;
        new_unit.hp    = spawn_stats.hp;
        new_unit.act   = tdg_pkg::MOVE;
    end

    assign spawn_ready = (phase == spawn_ph) && spawn.valid && free_found;

    always_ff @(posedge clk_25MHz or negedge arst_n) begin
        if (!arst_n) begin
            bank         <= '0;
            foe_tower_hp <= `TOWER_HP_INIT;
        end else begin
            if (spawn_ready) begin
                bank[free_idx] <= new_unit;
            end
            if (act_apply) begin
                bank[slot[idx_w-1:0]] <= own_next;
            end
            if (act_apply && tower_hit) begin
                foe_tower_hp <= (atk_ext >= foe_tower_hp) ? '0 : foe_tower_hp - atk_ext;
            end
            if (hit_in.valid) begin                             // Only in the foe's act phase
                bank[hit_in.slot[idx_w-1:0]].damage <=
                    bank[hit_in.slot[idx_w-1:0]].damage + hit_in.amount;
            end
            if (phase == hurt_ph) begin
                for (int i = 0; i < `UNIT_SLOTS; i++) begin
                    if (bank[i].exist) begin
                        if (bank[i].damage >= bank[i].hp) begin
                            bank[i] <= '0;                      // Killed
                        end else begin
                            bank[i].hp     <= bank[i].hp - bank[i].damage;
                            bank[i].damage <= '0;
                        end
                    end
                end
            end
        end
    end

endmodule

// File: hdl/unit_behavior.sv
`timescale 1ns/100ps
`include "tdg_consts.svh"

module unit_behavior #(
    parameter bit side_enemy = 1'b1
) (
    input  tdg_pkg::unit_t       own,
    input  tdg_pkg::unit_t       foe,
    input  tdg_pkg::unit_stats_t stats,
    input  logic                 target_end,
    output tdg_pkg::unit_t       own_next,
    output logic                 hit_foe,
    output logic                 tower_hit,
    output logic                 slot_done
);

    logic [`X_W:0]   own_x;
    logic [`X_W:0]   foe_x;
    logic [`X_W:0]   range_ext;
    logic [`X_W-1:0] speed_ext;
    logic            foe_in_range;
    logic            tower_in_range;

    assign own_x     = {1'b0, own.x};
    assign foe_x     = {1'b0, foe.x};
    assign range_ext = {{(`X_W + 1 - `RANGE_W){1'b0}}, stats.range};
    assign speed_ext = {{(`X_W - `SPEED_W){1'b0}}, stats.speed};

    // Enemies march up in x, the army marches down
    assign foe_in_range   = foe.exist && (side_enemy ? (own_x + range_ext >= foe_x)
                                                     : (own_x <= foe_x + range_ext));
    assign tower_in_range = side_enemy ? (own_x + range_ext >= {1'b0, `TOWER_A_X})
                                       : ({1'b0, `TOWER_E_X} + range_ext >= own_x);

    always_comb begin
        own_next  = own;
        hit_foe   = 1'b0;
        tower_hit = 1'b0;
        slot_done = 1'b1;
        if (own.exist) begin
            case (own.act)
                tdg_pkg::MOVE: begin
                    if (target_end) begin
                        if (tower_in_range) begin
                            own_next.act     = tdg_pkg::WINDUP;
                            own_next.act_cnt = '0;
                        end else if (side_enemy) begin
                            own_next.x = own.x + speed_ext;
                        end else begin
                            own_next.x = own.x - speed_ext;
                        end
                    end else if (foe_in_range) begin          // First foe in reach
                        own_next.act     = tdg_pkg::WINDUP;
                        own_next.act_cnt = '0;
                    end else begin
                        slot_done = 1'b0;
                    end
                end
                tdg_pkg::WINDUP, tdg_pkg::RECOVER: begin
                    if (own.act_cnt == stats.cooldown) begin
                        own_next.act = (own.act == tdg_pkg::WINDUP) ? tdg_pkg::STRIKE
                                                                    : tdg_pkg::MOVE;
                        own_next.act_cnt = '0;
                    end else begin
                        own_next.act_cnt = own.act_cnt + 1'b1;
                    end
                end
                tdg_pkg::STRIKE: begin
                    if (target_end) begin
                        tower_hit        = tower_in_range;
                        own_next.act     = tdg_pkg::RECOVER;
                        own_next.act_cnt = {{(`CNT_W - 1){1'b0}}, 1'b1};   // Strike pass counts
                    end else begin
                        hit_foe   = foe_in_range;               // Area damage, one foe per cycle
                        slot_done = 1'b0;
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/unit_stats_rom.sv
`timescale 1ns/100ps

module unit_stats_rom (
    input  tdg_pkg::unit_kind_e  kind,
    output tdg_pkg::unit_stats_t stats
);

    // hp, atk, cooldown, speed, range
    always_comb begin
        case (kind)
            tdg_pkg::SCOUT: begin
                stats = {12'd100, 9'd20, 4'd2, 5'd8, 8'd20};
            end
            tdg_pkg::BRUTE: begin
                stats = {12'd400, 9'd40, 4'd4, 5'd4, 8'd10};
            end
            tdg_pkg::ARCHER: begin
                stats = {12'd80, 9'd15, 4'd3, 5'd5, 8'd120};    // Long reach, fragile
            end
            tdg_pkg::TANK: begin
                stats = {12'd800, 9'd10, 4'd6, 5'd2, 8'd10};
            end
        endcase
    end

endmodule

// File: hdl/game_sequencer.sv
`timescale 1ns/100ps
`include "tdg_consts.svh"

module game_sequencer (
    input  logic                 clk_25MHz,
    input  logic                 arst_n,
    input  logic                 frame_tick,
    input  logic                 slot_done,
    input  logic                 game_win,
    input  logic                 game_lose,
    output tdg_pkg::game_phase_e phase,
    output logic [`SLOT_W-1:0]   slot,
    output logic [`SLOT_W-1:0]   target,
    output logic                 target_end,
    output logic                 pass_done
);

    assign target_end = (target == `UNIT_SLOTS);

    always_ff @(posedge clk_25MHz or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= tdg_pkg::REST;
            slot      <= '0;
            target    <= '0;
            pass_done <= 1'b0;
        end else begin
            pass_done <= (phase == tdg_pkg::HURT_A);
            case (phase)
                tdg_pkg::REST: begin
                    if (frame_tick && !game_win && !game_lose) begin
                        phase <= tdg_pkg::SPAWN_E;
                    end
                end
                tdg_pkg::SPAWN_E: phase <= tdg_pkg::SPAWN_A;
                tdg_pkg::SPAWN_A: phase <= tdg_pkg::ACT_E;
                tdg_pkg::ACT_E, tdg_pkg::ACT_A: begin
                    if (slot == `UNIT_SLOTS) begin                  // Scan of this side over
                        phase  <= (phase == tdg_pkg::ACT_E) ? tdg_pkg::ACT_A : tdg_pkg::ECONOMY;
                        slot   <= '0;
                        target <= '0;
                    end else if (slot_done) begin
                        slot   <= slot + 1'b1;
                        target <= '0;
                    end else if (!target_end) begin
                        target <= target + 1'b1;
                    end
                end
                tdg_pkg::ECONOMY: phase <= tdg_pkg::HURT_E;
                tdg_pkg::HURT_E:  phase <= tdg_pkg::HURT_A;
                tdg_pkg::HURT_A:  phase <= tdg_pkg::REST;
            endcase
        end
    end

endmodule

// File: hdl/tdg_pkg.sv
`include "tdg_consts.svh"

package tdg_pkg;

    // ----------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------
    typedef enum logic [2:0] {
        REST, SPAWN_E, SPAWN_A, ACT_E, ACT_A, ECONOMY, HURT_E, HURT_A
    } game_phase_e;

    typedef enum logic [1:0] {
        MOVE, WINDUP, STRIKE, RECOVER
    } unit_act_e;

    typedef enum logic [1:0] {
        SCOUT, BRUTE, ARCHER, TANK
    } unit_kind_e;

    // ----------------------------------------------------------
    // Records
    // ----------------------------------------------------------
    typedef struct packed {
        logic                exist;
        unit_kind_e          kind;
        logic [`X_W-1:0]     x;
        logic [`HP_W-1:0]    hp;
        unit_act_e           act;
        logic [`CNT_W-1:0]   act_cnt;
        logic [`HP_W-1:0]    damage;   // Collected during the pass
    } unit_t;

    typedef unit_t [`UNIT_SLOTS-1:0] unit_bank_t;

    typedef struct packed {
        logic [`HP_W-1:0]    hp;
        logic [`ATK_W-1:0]   atk;
        logic [`CNT_W-1:0]   cooldown;
        logic [`SPEED_W-1:0] speed;
        logic [`RANGE_W-1:0] range;
    } unit_stats_t;

    typedef struct packed {
        logic                valid;
        unit_kind_e          kind;
    } spawn_req_t;

    typedef struct packed {
        logic                valid;
        logic [`SLOT_W-1:0]  slot;
        logic [`HP_W-1:0]    amount;
    } hit_t;

endpackage

// File: hdl/tdg_consts.svh
`ifndef TDG_CONSTS_SVH
`define TDG_CONSTS_SVH

// ----------------------------------------------------------
// Slot bank and field widths
// ----------------------------------------------------------
`define UNIT_SLOTS      8
`define SLOT_W          4
`define X_W             10
`define HP_W            12
`define ATK_W           9
`define CNT_W           4
`define SPEED_W         5
`define RANGE_W         8
`define MONEY_W         15
`define LEVEL_W         3

// ----------------------------------------------------------
// Lane positions and towers
// ----------------------------------------------------------
`define ENEMY_SPAWN_X   10'd10
`define ARMY_SPAWN_X    10'd570
`define TOWER_E_X       10'd70
`define TOWER_A_X       10'd570

`define TOWER_HP_INIT   12'd4000
`define PURSE_MAX_LEVEL 3'd7

`endif
